// File: Makefile
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vpix_controller_tb: $(SRCS) pix_controller.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module pix_controller_tb -f pix_controller.f

run: obj_dir/Vpix_controller_tb
	./obj_dir/Vpix_controller_tb > sim.log 2>&1; cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/bank_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module bank_fifo #(
    parameter int fifo_depth_log2 = 3
) (
    input  logic               arst_n,

    input  logic               w_clk,
    input  logic               flush,
    output logic               flush_done,
    output logic               w_ready,
    input  logic               w_trigger,
    input  pix_pkg::pix_word_t w_data,

    input  logic               r_clk,
    output logic               r_ready,
    input  logic               r_trigger,
    output pix_pkg::pix_word_t r_data
);

    import pix_pkg::*;

    localparam int aw = fifo_depth_log2;

    function automatic logic [aw:0] to_gray(input logic [aw:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    pix_word_t mem [2**aw];

    // ====================
    // Write side
    // ====================

    logic [aw:0] w_bin;
    logic [aw:0] w_gray;
    logic [aw:0] r_gray;
    logic [aw:0] r_gray_w1;
    logic [aw:0] r_gray_w2;
    logic        flush_q;
    logic        flush_busy;
    logic        req_toggle;
    logic        ack_pulse;
    logic        w_full;
    logic        w_push;

    // Full when the pointers differ only in their two top Gray bits
    assign w_full  = (w_gray == {~r_gray_w2[aw:aw-1], r_gray_w2[aw-2:0]});
    assign w_ready = !w_full && !flush_busy;
    assign w_push  = w_trigger && w_ready;

    always_ff @(posedge w_clk or negedge arst_n) begin
        if (!arst_n) begin
            w_bin      <= '0;
            w_gray     <= '0;
            r_gray_w1  <= '0;
            r_gray_w2  <= '0;
            flush_q    <= 1'b0;
            flush_busy <= 1'b0;
            req_toggle <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            r_gray_w1 <= r_gray;
            r_gray_w2 <= r_gray_w1;
            flush_q   <= flush;
            if (flush != flush_q) begin
                // Clear our side first, then ask the read side
                w_bin      <= '0;
                w_gray     <= '0;
                flush_busy <= 1'b1;
                req_toggle <= !req_toggle;
            end else if (ack_pulse) begin
                flush_busy <= 1'b0;
                flush_done <= !flush_done;
            end else if (w_push) begin
                w_bin  <= w_bin + 1'b1;
                w_gray <= to_gray(w_bin + 1'b1);
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_push) mem[w_bin[aw-1:0]] <= w_data;
    end

    // ====================
    // Read side
    // ====================

    logic [aw:0] r_bin;
    logic [aw:0] w_gray_r1;
    logic [aw:0] w_gray_r2;
    logic        req_pulse;
    logic        ack_toggle;

    assign r_ready = (r_gray != w_gray_r2);
    assign r_data  = mem[r_bin[aw-1:0]];

    always_ff @(posedge r_clk or negedge arst_n) begin
        if (!arst_n) begin
            r_bin      <= '0;
            r_gray     <= '0;
            w_gray_r1  <= '0;
            w_gray_r2  <= '0;
            ack_toggle <= 1'b0;
        end else begin
            w_gray_r1 <= w_gray;
            w_gray_r2 <= w_gray_r1;
            if (req_pulse) begin
                r_bin      <= '0;
                r_gray     <= '0;
                ack_toggle <= !ack_toggle;
            end else if (r_trigger && r_ready) begin
                r_bin  <= r_bin + 1'b1;
                r_gray <= to_gray(r_bin + 1'b1);
            end
        end
    end

    // Flush request into the read domain, acknowledgement back
    toggle_pulse u_req_sync (
        .clk       (r_clk),
        .arst_n    (arst_n),
        .toggle_in (req_toggle),
        .pulse     (req_pulse)
    );

    toggle_pulse u_ack_sync (
        .clk       (w_clk),
        .arst_n    (arst_n),
        .toggle_in (ack_toggle),
        .pulse     (ack_pulse)
    );

endmodule

`default_nettype wire

// File: design/frame_store.sv
`timescale 1ns/100ps
`default_nettype none

module frame_store #(
    parameter int image_size  = 64,
    parameter int init_cycles = 50
) (
    input  logic               clk,
    input  logic               arst_n,

    input  pix_pkg::ram_cmd_t  cmd,

    output logic               write_ready,
    input  logic               write_trigger,
    input  pix_pkg::pix_word_t write_data,
    output logic               write_done,

    output logic               read_ready,
    input  logic               read_trigger,
    output pix_pkg::pix_word_t read_data,
    output logic               read_done
);

    import pix_pkg::*;

    localparam int blocks = 2**block_bits;
    localparam int aw     = $clog2(blocks * image_size);
    localparam int cw     = $clog2(image_size);
    localparam int iw     = $clog2(init_cycles + 1);

    typedef enum logic [1:0] {
        m_idle,
        m_write,
        m_read
    } mode_t;

    pix_word_t mem [blocks * image_size];

    logic            init_done;
    logic [iw-1:0]   init_cnt;
    ram_cmd_t        pend_cmd;
    ram_cmd_t        act_cmd;
    logic            cmd_valid;
    mode_t           mode;
    logic [aw-1:0]   addr;
    logic [aw-1:0]   base_addr;
    logic [cw-1:0]   count;
    logic            last_word;
    logic            wr_en;
    logic            rd_en;
    logic [aw-1:0]   rd_addr;

    // A command that arrives during init is held until init ends
    assign act_cmd   = (cmd.op != ram_none) ? cmd : pend_cmd;
    assign cmd_valid = init_done && (act_cmd.op != ram_none);
    assign base_addr = aw'(act_cmd.block) * aw'(image_size);
    assign last_word = (count == cw'(image_size - 1));

    assign write_ready = (mode == m_write);
    assign wr_en       = write_ready && write_trigger && !cmd_valid;

    always_comb begin
        rd_en   = 1'b0;
        rd_addr = addr;
        if (cmd_valid && act_cmd.op == ram_read) begin
            rd_en   = 1'b1;
            rd_addr = base_addr;
        end else if (!cmd_valid && mode == m_read && !read_ready) begin
            rd_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[addr] <= write_data;
        if (rd_en) read_data <= mem[rd_addr];
    end

    // ====================
    // Session control
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_cnt   <= '0;
            init_done  <= 1'b0;
            pend_cmd   <= '0;
            mode       <= m_idle;
            addr       <= '0;
            count      <= '0;
            read_ready <= 1'b0;
            write_done <= 1'b0;
            read_done  <= 1'b0;
        end else begin
            write_done <= 1'b0;
            read_done  <= 1'b0;
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == iw'(init_cycles - 1)) init_done <= 1'b1;
                if (cmd.op != ram_none) pend_cmd <= cmd;
            end else if (cmd_valid) begin
                // Any command ends the running session
                pend_cmd   <= '0;
                count      <= '0;
                read_ready <= 1'b0;
                case (act_cmd.op)
                    ram_write: begin
                        mode <= m_write;
                        addr <= base_addr;
                    end
                    ram_read: begin
                        // First word is fetched along with the command
                        mode       <= m_read;
                        addr       <= base_addr + 1'b1;
                        read_ready <= 1'b1;
                    end
                    default: mode <= m_idle;
                endcase
            end else begin
                case (mode)
                    m_write: begin
                        if (write_trigger) begin
                            addr  <= addr + 1'b1;
                            count <= count + 1'b1;
                            if (last_word) begin
                                mode       <= m_idle;
                                write_done <= 1'b1;
                            end
                        end
                    end
                    m_read: begin
                        if (!read_ready) begin
                            read_ready <= 1'b1;
                            addr       <= addr + 1'b1;
                        end else if (read_trigger) begin
                            read_ready <= 1'b0;
                            count      <= count + 1'b1;
                            if (last_word) begin
                                mode      <= m_idle;
                                read_done <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pix_capture.sv
`timescale 1ns/100ps
`default_nettype none

module pix_capture (
    input  logic               pix_dclk,
    input  logic               arst_n,
    input  pix_pkg::pix_in_t   pix,
    input  logic               start_toggle,
    output logic               fifo_flush,
    input  logic               fifo_flush_done,
    input  logic               fifo_w_ready,
    output logic               fifo_w_trigger,
    output pix_pkg::pix_word_t fifo_w_data
);

    import pix_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_flush,
        s_wait_flush,
        s_wait_fv_low,
        s_wait_fv_high,
        s_stream
    } state_t;

    state_t  state;
    pix_in_t pix_q;
    logic    start_pulse;
    logic    flush_done_pulse;
    logic    in_frame;

    // Pin registers
    always_ff @(posedge pix_dclk or negedge arst_n) begin
        if (!arst_n) pix_q <= '0;
        else         pix_q <= pix;
    end

    toggle_pulse u_start_sync (
        .clk       (pix_dclk),
        .arst_n    (arst_n),
        .toggle_in (start_toggle),
        .pulse     (start_pulse)
    );

    toggle_pulse u_flush_done_sync (
        .clk       (pix_dclk),
        .arst_n    (arst_n),
        .toggle_in (fifo_flush_done),
        .pulse     (flush_done_pulse)
    );

    // The first sample with fv high is already part of the frame
    assign in_frame       = (state == s_stream) || (state == s_wait_fv_high);
    assign fifo_w_trigger = in_frame && pix_q.fv && pix_q.lv;
    assign fifo_w_data    = pix_word_t'(pix_q.d);

    always_ff @(posedge pix_dclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= s_idle;
            fifo_flush <= 1'b0;
        end else if (start_pulse) begin
            state <= s_flush;
        end else begin
            case (state)
                s_flush: begin
                    fifo_flush <= !fifo_flush;
                    state      <= s_wait_flush;
                end
                s_wait_flush:   if (flush_done_pulse) state <= s_wait_fv_low;
                // Skip the rest of a frame already in progress
                s_wait_fv_low:  if (!pix_q.fv) state <= s_wait_fv_high;
                s_wait_fv_high: if (pix_q.fv) state <= s_stream;
                s_stream:       if (!pix_q.fv) state <= s_idle;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/pix_controller.sv
`timescale 1ns/100ps
`default_nettype none

module pix_controller #(
    parameter int image_size      = 64,
    parameter int fifo_depth_log2 = 3,
    parameter int init_cycles     = 50
) (
    input  logic                           clk,
    input  logic                           arst_n,

    input  pix_pkg::pix_cmd_e              cmd,
    input  logic [pix_pkg::block_bits-1:0] cmd_block,

    output logic                           capture_done,

    output logic                           readout_ready,
    input  logic                           readout_trigger,
    output pix_pkg::pix_word_t             readout_data,
    output logic                           readout_done,

    input  logic                           pix_dclk,
    input  pix_pkg::pix_in_t               pix
);

    import pix_pkg::*;

    // ====================
    // Frame store
    // ====================

    ram_cmd_t  ram_cmd;
    logic      ram_write_ready;
    logic      ram_write_trigger;
    pix_word_t ram_write_data;
    logic      ram_write_done;

    frame_store #(
        .image_size  (image_size),
        .init_cycles (init_cycles)
    ) u_frame_store (
        .clk           (clk),
        .arst_n        (arst_n),
        .cmd           (ram_cmd),
        .write_ready   (ram_write_ready),
        .write_trigger (ram_write_trigger),
        .write_data    (ram_write_data),
        .write_done    (ram_write_done),
        .read_ready    (readout_ready),
        .read_trigger  (readout_trigger),
        .read_data     (readout_data),
        .read_done     (readout_done)
    );

    // ====================
    // FIFO and sensor side
    // ====================

    logic      fifo_flush;
    logic      fifo_flush_done;
    logic      fifo_w_ready;
    logic      fifo_w_trigger;
    pix_word_t fifo_w_data;
    logic      fifo_r_ready;
    logic      fifo_r_trigger;
    pix_word_t fifo_r_data;
    logic      capture_start;
    logic      flush_done_pulse;

    bank_fifo #(
        .fifo_depth_log2 (fifo_depth_log2)
    ) u_bank_fifo (
        .arst_n     (arst_n),
        .w_clk      (pix_dclk),
        .flush      (fifo_flush),
        .flush_done (fifo_flush_done),
        .w_ready    (fifo_w_ready),
        .w_trigger  (fifo_w_trigger),
        .w_data     (fifo_w_data),
        .r_clk      (clk),
        .r_ready    (fifo_r_ready),
        .r_trigger  (fifo_r_trigger),
        .r_data     (fifo_r_data)
    );

    pix_capture u_pix_capture (
        .pix_dclk        (pix_dclk),
        .arst_n          (arst_n),
        .pix             (pix),
        .start_toggle    (capture_start),
        .fifo_flush      (fifo_flush),
        .fifo_flush_done (fifo_flush_done),
        .fifo_w_ready    (fifo_w_ready),
        .fifo_w_trigger  (fifo_w_trigger),
        .fifo_w_data     (fifo_w_data)
    );

    toggle_pulse u_flush_done_sync (
        .clk       (clk),
        .arst_n    (arst_n),
        .toggle_in (fifo_flush_done),
        .pulse     (flush_done_pulse)
    );

    // ====================
    // Command FSM
    // ====================

    typedef enum logic [1:0] {
        s_idle,
        s_wait_ready,
        s_wait_flush,
        s_copy
    } state_t;

    state_t state;
    logic   fifo_pop;

    // Pop only when the held word is empty or being accepted
    assign fifo_r_trigger = (state == s_copy) && (!ram_write_trigger || ram_write_ready);
    assign fifo_pop       = fifo_r_trigger && fifo_r_ready;

    always_ff @(posedge clk) begin
        if (fifo_pop) ram_write_data <= fifo_r_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state             <= s_idle;
            ram_cmd           <= '0;
            ram_write_trigger <= 1'b0;
            capture_done      <= 1'b0;
            capture_start     <= 1'b0;
        end else begin
            ram_cmd      <= '0;
            capture_done <= 1'b0;
            case (cmd)
                cmd_capture: begin
                    ram_cmd           <= '{op: ram_write, block: cmd_block};
                    ram_write_trigger <= 1'b0;
                    state             <= s_wait_ready;
                end
                cmd_readout: begin
                    ram_cmd           <= '{op: ram_read, block: cmd_block};
                    ram_write_trigger <= 1'b0;
                    state             <= s_idle;
                end
                cmd_stop: begin
                    ram_cmd           <= '{op: ram_stop, block: cmd_block};
                    ram_write_trigger <= 1'b0;
                    state             <= s_idle;
                end
                default: begin
                    case (state)
                        // Store may still be in its init delay
                        s_wait_ready: begin
                            if (ram_write_ready) begin
                                capture_start <= !capture_start;
                                state         <= s_wait_flush;
                            end
                        end
                        // Old FIFO contents are gone once the flush is done
                        s_wait_flush: if (flush_done_pulse) state <= s_copy;
                        s_copy: begin
                            if (fifo_pop) begin
                                ram_write_trigger <= 1'b1;
                            end else if (ram_write_trigger && ram_write_ready) begin
                                ram_write_trigger <= 1'b0;
                            end
                            if (ram_write_done) begin
                                ram_write_trigger <= 1'b0;
                                capture_done      <= 1'b1;
                                state             <= s_idle;
                            end
                        end
                        default: ;
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/pix_pkg.sv
`default_nettype none

package pix_pkg;

    // ====================
    // Widths
    // ====================

    localparam int block_bits = 3;
    localparam int pix_bits   = 12;
    localparam int word_bits  = 16;

    // ====================
    // Commands
    // ====================

    // External command strobe
    typedef enum logic [1:0] {
        cmd_none    = 2'b00,
        cmd_capture = 2'b01,
        cmd_readout = 2'b10,
        cmd_stop    = 2'b11
    } pix_cmd_e;

    // Frame store operation
    typedef enum logic [1:0] {
        ram_none  = 2'b00,
        ram_write = 2'b01,
        ram_read  = 2'b10,
        ram_stop  = 2'b11
    } ram_op_e;

    typedef struct packed {
        ram_op_e               op;
        logic [block_bits-1:0] block;
    } ram_cmd_t;

    // ====================
    // Data
    // ====================

    // Sensor pins as sampled on pix_dclk
    typedef struct packed {
        logic [pix_bits-1:0] d;
        logic                fv;
        logic                lv;
    } pix_in_t;

    // FIFO and memory word, pixel in the low bits
    typedef logic [word_bits-1:0] pix_word_t;

endpackage

`default_nettype wire

// File: design/toggle_pulse.sv
`timescale 1ns/100ps
`default_nettype none

module toggle_pulse (
    input  logic clk,
    input  logic arst_n,
    input  logic toggle_in,
    output logic pulse
);

    // Two synchronizer stages, then the previous synchronized level
    logic [1:0] sync;
    logic       last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync <= 2'b00;
            last <= 1'b0;
        end else begin
            sync <= {sync[0], toggle_in};
            last <= sync[1];
        end
    end

    // One cycle high for every change of the toggle
    assign pulse = sync[1] ^ last;

endmodule

`default_nettype wire

// File: pix_controller.f
design/pix_pkg.sv
design/toggle_pulse.sv
design/bank_fifo.sv
design/frame_store.sv
design/pix_capture.sv
design/pix_controller.sv
tests/pix_controller_asserts.sv
tests/pix_controller_tb.sv

// File: tests/pix_controller_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module pix_controller_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               pix_dclk,
    input logic               capture_done,
    input logic               readout_ready,
    input logic               readout_trigger,
    input pix_pkg::pix_word_t readout_data,
    input logic               readout_done,
    input logic               fifo_w_trigger,
    input logic               fifo_w_ready
);

    // Word on offer holds until it is taken
    data_held: assert property (@(posedge clk) disable iff (!arst_n)
        readout_ready && !readout_trigger |=> !readout_ready || $stable(readout_data))
        else $error("readout_data changed while waiting for a trigger");

    capture_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        capture_done |=> !capture_done)
        else $error("capture_done high for more than one cycle");

    readout_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        readout_done |=> !readout_done)
        else $error("readout_done high for more than one cycle");

    // A push into a full FIFO would lose a pixel
    no_drop: assert property (@(posedge pix_dclk) disable iff (!arst_n)
        fifo_w_trigger |-> fifo_w_ready)
        else $error("pixel pushed while the FIFO was full");

endmodule

bind pix_controller pix_controller_asserts u_asserts (
    .clk             (clk),
    .arst_n          (arst_n),
    .pix_dclk        (pix_dclk),
    .capture_done    (capture_done),
    .readout_ready   (readout_ready),
    .readout_trigger (readout_trigger),
    .readout_data    (readout_data),
    .readout_done    (readout_done),
    .fifo_w_trigger  (fifo_w_trigger),
    .fifo_w_ready    (fifo_w_ready)
);

`default_nettype wire

// File: tests/pix_controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pix_controller_tb;

    import pix_pkg::*;

    localparam int image_size  = 64;
    localparam int init_cycles = 50;
    localparam int lines       = 8;
    localparam int line_pixels = 8;
    localparam int line_blank  = 4;
    localparam int frame_blank = 60;
    localparam int clk_half    = 20;
    localparam int dclk_half   = 48;

    // Sensor clocks per frame, two porch clocks before the first line
    localparam int frame_dclks = frame_blank + 2 + lines * (line_pixels + line_blank);
    localparam int frame_ns    = frame_dclks * 2 * dclk_half;
    localparam int frame_clks  = frame_ns / (2 * clk_half);
    localparam int watchdog_ns = 8 * frame_ns + 2000 * 2 * clk_half;

    logic                  clk;
    logic                  arst_n;
    pix_cmd_e              cmd;
    logic [block_bits-1:0] cmd_block;
    logic                  capture_done;
    logic                  readout_ready;
    logic                  readout_trigger;
    pix_word_t             readout_data;
    logic                  readout_done;
    logic                  pix_dclk;
    pix_in_t               pix;

    // Expected pixels per block, and the readout position
    pix_word_t exp_q [2**block_bits][$];
    pix_word_t exp_head;
    int        rd_block;
    int        rd_idx;

    logic cap_pending;
    int   cap_block;
    logic frame_active;
    logic quiet;
    logic no_done;
    int   value_errors;
    int   other_errors;

    pix_controller #(
        .image_size      (image_size),
        .fifo_depth_log2 (3),
        .init_cycles     (init_cycles)
    ) DUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .capture_done    (capture_done),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .readout_done    (readout_done),
        .pix_dclk        (pix_dclk),
        .pix             (pix)
    );

    always #(clk_half) clk = ~clk;
    always #(dclk_half) pix_dclk = ~pix_dclk;

    // ====================
    // Checks
    // ====================

    quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        quiet |-> !capture_done && !readout_done && !readout_ready)
        else begin
            other_errors++;
            $display("Done pulse or readout_ready seen right after reset");
        end

    readout_word: assert property (@(posedge clk) disable iff (!arst_n)
        readout_trigger && readout_ready |-> readout_data == exp_head)
        else begin
            value_errors++;
            $display("** Error: readout_data = %h, expected %h (block %0d word %0d)",
                     $sampled(readout_data), $sampled(exp_head),
                     $sampled(rd_block), $sampled(rd_idx));
        end

    ready_after_readout: assert property (@(posedge clk) disable iff (!arst_n)
        cmd == cmd_readout |-> ##2 readout_ready)
        else begin
            value_errors++;
            $display("** Error: readout_ready = %h, expected %h two cycles after readout",
                     $sampled(readout_ready), 1'b1);
        end

    ready_after_stop: assert property (@(posedge clk) disable iff (!arst_n)
        cmd == cmd_stop |-> ##2 !readout_ready)
        else begin
            value_errors++;
            $display("** Error: readout_ready = %h, expected %h two cycles after stop",
                     $sampled(readout_ready), 1'b0);
        end

    done_after_block: assert property (@(posedge clk) disable iff (!arst_n)
        readout_done |-> rd_idx == image_size)
        else begin
            value_errors++;
            $display("** Error: words before readout_done = %h, expected %h",
                     $sampled(rd_idx), image_size);
        end

    no_done_after_stop: assert property (@(posedge clk) disable iff (!arst_n)
        no_done |-> !readout_done)
        else begin
            other_errors++;
            $display("readout_done pulsed after the readout was stopped");
        end

    // ====================
    // Stimulus
    // ====================

    // Endless frames, recording the first one that starts after a capture
    task automatic run_sensor();
        int   rec_block;
        logic recording;
        int   line;
        int   col;
        forever begin
            repeat (frame_blank) @(negedge pix_dclk);
            recording = 1'b0;
            if (cap_pending) begin
                rec_block   = cap_block;
                recording   = 1'b1;
                cap_pending = 1'b0;
                exp_q[rec_block].delete();
            end
            frame_active = 1'b1;
            pix.fv       = 1'b1;
            repeat (2) @(negedge pix_dclk);
            for (line = 0; line < lines; line++) begin
                for (col = 0; col < line_pixels; col++) begin
                    pix.lv = 1'b1;
                    pix.d  = 12'($urandom);
                    if (recording) exp_q[rec_block].push_back(pix_word_t'(pix.d));
                    @(negedge pix_dclk);
                end
                pix.lv = 1'b0;
                pix.d  = '0;
                repeat (line_blank) @(negedge pix_dclk);
            end
            pix.fv       = 1'b0;
            frame_active = 1'b0;
        end
    endtask

    task automatic send_cmd(input pix_cmd_e op, input int blk);
        @(negedge clk);
        cmd       = op;
        cmd_block = block_bits'(blk);
        @(negedge clk);
        cmd = cmd_none;
    endtask

    task automatic capture_into(input int blk);
        int waited;
        cap_block   = blk;
        cap_pending = 1'b1;
        send_cmd(cmd_capture, blk);
        waited = 0;
        while (!capture_done && waited < 3 * frame_clks) begin
            @(negedge clk);
            waited++;
        end
        if (!capture_done) begin
            other_errors++;
            $display("Capture into block %0d never finished", blk);
        end
    endtask

    // Reads a number of words with random stalls
    task automatic read_block(input int blk, input int words);
        logic fire;
        int   waited;
        rd_block = blk;
        rd_idx   = 0;
        exp_head = exp_q[blk][0];
        send_cmd(cmd_readout, blk);
        waited = 0;
        while (rd_idx < words && waited < 20 * image_size) begin
            fire            = readout_ready && ($urandom_range(3) != 0);
            readout_trigger = fire;
            @(negedge clk);
            waited++;
            if (fire) begin
                rd_idx++;
                if (rd_idx < image_size) exp_head = exp_q[blk][rd_idx];
            end
        end
        readout_trigger = 1'b0;
        if (rd_idx < words) begin
            other_errors++;
            $display("Readout of block %0d stalled after %0d words", blk, rd_idx);
        end else if (words == image_size) begin
            waited = 0;
            while (!readout_done && waited < 4) begin
                @(negedge clk);
                waited++;
            end
            if (!readout_done) begin
                other_errors++;
                $display("No readout_done after the last word of block %0d", blk);
            end
            // Word count stays put until the done pulse has been sampled
            @(negedge clk);
        end
    endtask

    task automatic stop_readout();
        send_cmd(cmd_stop, rd_block);
        no_done = 1'b1;
        // Triggers go on long enough for a running readout to reach its last word
        repeat (2 * image_size) begin
            readout_trigger = readout_ready;
            @(negedge clk);
        end
        readout_trigger = 1'b0;
        no_done         = 1'b0;
    endtask

    initial begin
        clk             = 1'b0;
        pix_dclk        = 1'b0;
        arst_n          = 1'b0;
        cmd             = cmd_none;
        cmd_block       = '0;
        readout_trigger = 1'b0;
        pix             = '0;
        cap_pending     = 1'b0;
        cap_block       = 0;
        frame_active    = 1'b0;
        quiet           = 1'b0;
        no_done         = 1'b0;
        rd_block        = 0;
        rd_idx          = 0;
        exp_head        = '0;
        value_errors    = 0;
        other_errors    = 0;
        void'($urandom(91273));

        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        fork
            run_sensor();
        join_none

        // Store is still in its init delay here
        quiet = 1'b1;
        repeat (8) @(negedge clk);
        quiet = 1'b0;
        capture_into(0);
        read_block(0, image_size);

        // Capture given in the middle of a frame
        wait (!frame_active);
        wait (frame_active);
        repeat (40) @(negedge pix_dclk);
        capture_into(2);

        // Capture given just after a frame ends
        wait (frame_active);
        wait (!frame_active);
        capture_into(5);

        read_block(5, image_size);
        read_block(2, image_size);

        // Stop partway, then the same block again from word 0
        read_block(2, 20);
        stop_readout();
        read_block(2, image_size);

        repeat (10) @(negedge clk);
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, the test sequence did not finish", watchdog_ns);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
